//--- rv_fetch_top.f
source/rv_fetch_pkg.sv
source/fifo_dual.sv
source/rv_fetch_buf.sv
source/rv_fetch_pc.sv
source/rv_fetch_top.sv
verif/rv_fetch_mem_model.sv
verif/rv_fetch_tb.sv

//--- verif/rv_fetch_tb.sv
module rv_fetch_tb
    import rv_fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          BUF_BITS  = 2;
    localparam logic [31:0] RESET_PC  = 32'h0000_0040;
    localparam int          IMG_BITS  = 12;      // 4 KB image
    localparam logic [1:0]  STALL_OFF = 2'd0;
    localparam logic [1:0]  STALL_RND = 2'd1;
    localparam logic [1:0]  STALL_ON  = 2'd2;

    logic        clk;
    logic        rst_n;
    logic        stall      = 1'b0;
    logic [1:0]  stall_mode = STALL_OFF;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_ack;
    logic [31:0] mem_data;
    logic        ack_due;
    logic        o_instr_valid;
    logic [31:0] o_instr;
    logic [31:0] o_instr_pc;
    logic        consume;                        // Decode takes the instruction
    logic [31:0] exp_pc;                         // Walker PC
    logic [15:0] exp_lo;
    logic [15:0] exp_hi;
    logic        exp_c;
    logic        rst_d      = 1'b0;              // Reset seen one edge ago
    logic        hold_q     = 1'b0;              // Stalled valid instruction last cycle
    logic [31:0] pc_q;
    logic [31:0] instr_q;
    logic        req_wait_q = 1'b0;              // Read open and not acked last cycle
    logic [31:0] addr_q;
    int          cycle_cnt  = 0;
    int          stall_run  = 0;
    int          n_consumed = 0;
    int unsigned seed;

    rv_fetch_top #(
        .INSTR_BUF_ADDR_SIZE (BUF_BITS),
        .RESET_PC            (RESET_PC)
    ) dut_i (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_stall       (stall),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_mem_ack     (mem_ack),
        .i_mem_data    (mem_data),
        .o_mem_req     (mem_req),
        .o_mem_addr    (mem_addr),
        .o_instr_valid (o_instr_valid),
        .o_instr       (o_instr),
        .o_instr_pc    (o_instr_pc)
    );

    rv_fetch_mem_model #(
        .ADDR_BITS  (IMG_BITS)
    ) mem_i (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_mem_req  (mem_req),
        .i_mem_addr (mem_addr),
        .o_mem_ack  (mem_ack),
        .o_mem_data (mem_data),
        .o_ack_due  (ack_due)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at cycle %0d", cycle_cnt);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        stop_run();
    endtask

    task automatic report_problem(input string msg);
        $display("Error: %s", msg);
        stop_run();
    endtask

    // Parcel of the image at a halfword PC
    function automatic logic [15:0] parcel_at(input logic [31:0] pc);
        logic [31:0] word;
        word = mem_i.image[pc[IMG_BITS-1:2]];
        return pc[1] ? word[31:16] : word[15:0];
    endfunction

    assign consume = o_instr_valid && !stall;

    always_comb begin
        exp_lo = parcel_at(exp_pc);
        exp_hi = parcel_at(exp_pc + 32'd2);      // Second half of a 32-bit instruction
        exp_c  = is_compressed(exp_lo);
    end

    // Reference walker over the image
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_pc <= RESET_PC;
        end else if (redirect) begin
            exp_pc <= {redirect_pc[31:1], 1'b0};
        end else if (consume) begin
            exp_pc <= exp_pc + (exp_c ? 32'd2 : 32'd4);
        end
    end

    // Random or forced stall
    always @(posedge clk) begin
        case (stall_mode)
            STALL_OFF: stall <= 1'b0;
            STALL_RND: stall <= ($urandom_range(3, 0) == 0);   // About one in four
            default:   stall <= 1'b1;
        endcase
    end

    // History for the checks below
    always @(posedge clk) begin
        cycle_cnt  <= cycle_cnt + 1;
        rst_d      <= rst_n;
        hold_q     <= o_instr_valid && stall && !redirect;
        pc_q       <= o_instr_pc;
        instr_q    <= o_instr;
        req_wait_q <= mem_req && !mem_ack;
        addr_q     <= mem_addr;
        stall_run  <= (stall && !redirect) ? stall_run + 1 : 0;
        if (rst_n && consume) begin
            n_consumed <= n_consumed + 1;
        end
    end

    // Quiet during reset and the cycle after, first edge has no history
    a_reset_valid: assert property (@(posedge clk)
        (cycle_cnt >= 1 && !rst_d) |-> !o_instr_valid
    ) else report_mismatch("o_instr_valid", 32'($sampled(o_instr_valid)), 32'd0);

    a_reset_req: assert property (@(posedge clk)
        (cycle_cnt >= 1 && !rst_d) |-> !mem_req
    ) else report_mismatch("o_mem_req", 32'($sampled(mem_req)), 32'd0);

    a_first_pc: assert property (@(posedge clk) disable iff (!rst_n)
        (consume && n_consumed == 0) |-> o_instr_pc == RESET_PC
    ) else report_mismatch("o_instr_pc", $sampled(o_instr_pc), RESET_PC);

    // Instruction stream against the walker
    a_pc: assert property (@(posedge clk) disable iff (!rst_n)
        consume |-> o_instr_pc == exp_pc
    ) else report_mismatch("o_instr_pc", $sampled(o_instr_pc), $sampled(exp_pc));

    a_lo: assert property (@(posedge clk) disable iff (!rst_n)
        consume |-> o_instr[15:0] == exp_lo
    ) else report_mismatch("o_instr[15:0]", 32'($sampled(o_instr[15:0])),
                           32'($sampled(exp_lo)));

    a_hi: assert property (@(posedge clk) disable iff (!rst_n)
        (consume && !exp_c) |-> o_instr[31:16] == exp_hi
    ) else report_mismatch("o_instr[31:16]", 32'($sampled(o_instr[31:16])),
                           32'($sampled(exp_hi)));

    // Outputs frozen while decode stalls
    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
        hold_q |-> o_instr_valid
    ) else report_mismatch("o_instr_valid", 32'($sampled(o_instr_valid)), 32'd1);

    a_hold_pc: assert property (@(posedge clk) disable iff (!rst_n)
        hold_q |-> o_instr_pc == pc_q
    ) else report_mismatch("o_instr_pc", $sampled(o_instr_pc), $sampled(pc_q));

    a_hold_lo: assert property (@(posedge clk) disable iff (!rst_n)
        hold_q |-> o_instr[15:0] == instr_q[15:0]
    ) else report_mismatch("o_instr[15:0]", 32'($sampled(o_instr[15:0])),
                           32'($sampled(instr_q[15:0])));

    // Upper half only carries meaning for a 32-bit instruction
    a_hold_hi: assert property (@(posedge clk) disable iff (!rst_n)
        (hold_q && !is_compressed(instr_q[15:0])) |-> o_instr[31:16] == instr_q[31:16]
    ) else report_mismatch("o_instr[31:16]", 32'($sampled(o_instr[31:16])),
                           32'($sampled(instr_q[31:16])));

    // Memory side protocol
    a_req_align: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> mem_addr[1:0] == 2'b00
    ) else report_mismatch("o_mem_addr", $sampled(mem_addr),
                           {$sampled(mem_addr[31:2]), 2'b00});

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_wait_q |-> mem_req
    ) else report_mismatch("o_mem_req", 32'($sampled(mem_req)), 32'd1);

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_wait_q |-> mem_addr == addr_q
    ) else report_mismatch("o_mem_addr", $sampled(mem_addr), $sampled(addr_q));

    a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ack |-> mem_req
    ) else report_problem("memory ack arrived with no request open");

    // Full buffer stops fetching
    a_full_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_run >= 16) |-> !mem_req
    ) else report_mismatch("o_mem_req", 32'($sampled(mem_req)), 32'd0);

    // Let decode take n more instructions
    task automatic run_instrs(input int n);
        int target;
        int waited;
        target = n_consumed + n;
        waited = 0;
        while (n_consumed < target) begin
            @(posedge clk);
            waited++;
            if (waited > n * 40 + 100) begin
                report_problem($sformatf("only %0d of %0d instructions after %0d cycles",
                                         n - (target - n_consumed), n, waited));
            end
        end
    endtask

    // Redirect while a read is open and its ack is at least two edges away
    task automatic redirect_busy(input logic [31:0] target);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 100) begin
                report_problem("no outstanding read found for the redirect");
            end
        end while (!(mem_req && !mem_ack && !ack_due));
        redirect    <= 1'b1;
        redirect_pc <= target;
        @(posedge clk);
        redirect    <= 1'b0;
    endtask

    initial begin
        seed        = $urandom(45);
        rst_n       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        repeat (5) @(posedge clk);
        rst_n      <= 1'b1;
        stall_mode <= STALL_RND;
        run_instrs(60);
        stall_mode <= STALL_ON;                  // Long stall, buffer fills
        repeat (30) @(posedge clk);
        stall_mode <= STALL_RND;
        run_instrs(40);
        redirect_busy(32'h0000_0180);            // Word aligned target
        run_instrs(40);
        redirect_busy(32'h0000_02A6);            // Halfword aligned target
        run_instrs(60);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- verif/rv_fetch_mem_model.sv
module rv_fetch_mem_model #(
    parameter int ADDR_BITS = 12                 // log2 of image size in bytes
)
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_mem_req,
    input  logic [31:0] i_mem_addr,
    output logic        o_mem_ack,
    output logic [31:0] o_mem_data,
    output logic        o_ack_due                // Ack rises at the next edge
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS = 1 << (ADDR_BITS - 2);

    logic [31:0]          image [WORDS];         // Program image, one word per entry
    logic                 ack_q  = 1'b0;
    logic [31:0]          data_q = '0;
    logic                 busy_q = 1'b0;         // Read accepted, ack pending
    logic [1:0]           wait_q = '0;           // Extra cycles before the ack
    logic [ADDR_BITS-3:0] idx_q  = '0;           // Word index of the open read

    // Parcel contents from the full halfword address
    // Roughly one parcel in two starts a 32-bit instruction
    function automatic logic [15:0] image_parcel(input logic [31:0] half_idx);
        logic [31:0] h;
        logic [15:0] p;
        h = half_idx * 32'h9E37_79B1;
        h = h ^ (h >> 15);
        p = h[31:16];
        if (h[4]) begin
            p[1:0] = 2'b11;                      // 32-bit opcode space
        end else begin
            p[0] = 1'b0;                         // Quadrant 0 or 2, compressed
        end
        return p;
    endfunction

    // Upper parcel of each word is the odd halfword
    initial begin
        for (int w = 0; w < WORDS; w++) begin
            image[w] = {image_parcel(32'(2 * w + 1)), image_parcel(32'(2 * w))};
        end
    end

    // One read at a time, acked 1 to 4 cycles after it is seen
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q  <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;                       // Single-cycle pulse
            if (busy_q) begin
                if (wait_q == '0) begin
                    ack_q  <= 1'b1;
                    data_q <= image[idx_q];
                    busy_q <= 1'b0;
                end else begin
                    wait_q <= wait_q - 1'b1;
                end
            end else if (i_mem_req && !ack_q) begin
                // Request still high in the ack cycle is the old one
                idx_q  <= i_mem_addr[ADDR_BITS-1:2];   // Upper bits alias
                wait_q <= 2'($urandom_range(3, 0));
                busy_q <= 1'b1;
            end
        end
    end

    assign o_mem_ack  = ack_q;
    assign o_mem_data = data_q;
    assign o_ack_due  = busy_q && (wait_q == '0);

endmodule

//--- source/rv_fetch_top.sv
module rv_fetch_top
    import rv_fetch_pkg::*;
#(
    parameter int          INSTR_BUF_ADDR_SIZE = 2,
    parameter logic [31:0] RESET_PC            = 32'h0000_0000
)
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_stall,             // From decode
    input  logic        i_redirect,          // From execute
    input  logic [31:0] i_redirect_pc,
    input  logic        i_mem_ack,
    input  logic [31:0] i_mem_data,
    output logic        o_mem_req,
    output logic [31:0] o_mem_addr,
    output logic        o_instr_valid,
    output logic [31:0] o_instr,
    output logic [31:0] o_instr_pc
);

    logic                  free_dword;       // Buffer to sequencer credit
    logic                  fill_valid;
    logic [31:0]           fill_pc;
    logic [2*PARCEL_W-1:0] fill_data;        // Two parcels per memory word

    // Request side
    rv_fetch_pc #(
        .RESET_PC      (RESET_PC)
    ) u_pc (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_free_dword  (free_dword),
        .i_mem_ack     (i_mem_ack),
        .i_mem_data    (i_mem_data),
        .o_mem_req     (o_mem_req),
        .o_mem_addr    (o_mem_addr),
        .o_fill_valid  (fill_valid),
        .o_fill_pc     (fill_pc),
        .o_fill_data   (fill_data)
    );

    // Parcel buffer and instruction assembly
    rv_fetch_buf #(
        .INSTR_BUF_ADDR_SIZE (INSTR_BUF_ADDR_SIZE)
    ) u_buf (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_redirect),         // Same edge as the PC reload
        .i_stall       (i_stall),
        .i_fill_valid  (fill_valid),
        .i_fill_pc     (fill_pc),
        .i_fill_data   (fill_data),
        .o_free_dword  (free_dword),
        .o_instr_valid (o_instr_valid),
        .o_instr       (o_instr),
        .o_instr_pc    (o_instr_pc)
    );

endmodule

//--- source/rv_fetch_pc.sv
module rv_fetch_pc
    import rv_fetch_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
)
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_redirect,          // Load new fetch PC
    input  logic [31:0] i_redirect_pc,       // May be halfword aligned
    input  logic        i_free_dword,        // Buffer can take a word
    input  logic        i_mem_ack,
    input  logic [31:0] i_mem_data,
    output logic        o_mem_req,
    output logic [31:0] o_mem_addr,          // Always word aligned
    output logic        o_fill_valid,
    output logic [31:0] o_fill_pc,
    output logic [31:0] o_fill_data
);

    localparam logic [31:0] WORD_STEP = 32'(2 * PARCEL_W / 8);  // Bytes per read

    logic [31:0] fetch_pc;                   // Halfword aligned
    logic [31:0] next_word_pc;
    logic [31:0] start_pc;
    logic [31:2] mem_addr_q;                 // Address of the open read
    logic        req_q;                      // Read outstanding
    logic        stale_q;                    // Open read belongs to an old stream
    logic        start_req;

    assign next_word_pc = {fetch_pc[31:2], 2'b00} + WORD_STEP;

    // Redirect restarts at once unless a read is still waiting
    assign start_req = i_redirect ? (!req_q || i_mem_ack)
                                  : (!req_q && i_free_dword);
    assign start_pc  = i_redirect ? i_redirect_pc : fetch_pc;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            req_q    <= 1'b0;
            stale_q  <= 1'b0;
            fetch_pc <= {RESET_PC[31:1], 1'b0};
        end else begin
            if (start_req) begin
                req_q <= 1'b1;
            end else if (i_mem_ack) begin
                req_q <= 1'b0;                   // Read done, wait a cycle
            end

            if (i_redirect && req_q && !i_mem_ack) begin
                stale_q <= 1'b1;                 // Drop the data when it lands
            end else if (i_mem_ack) begin
                stale_q <= 1'b0;
            end

            if (i_redirect) begin
                fetch_pc <= {i_redirect_pc[31:1], 1'b0};
            end else if (o_fill_valid) begin
                fetch_pc <= next_word_pc;        // Next word after a fill
            end
        end
    end

    // Request address held for the whole transaction
    always_ff @(posedge i_clk) begin
        if (start_req) begin
            mem_addr_q <= start_pc[31:2];
        end
    end

    assign o_mem_req  = req_q;
    assign o_mem_addr = {mem_addr_q, 2'b00};

    // Stale acks close the read but never reach the buffer
    assign o_fill_valid = i_mem_ack && req_q && !stale_q;
    assign o_fill_pc    = fetch_pc;
    assign o_fill_data  = i_mem_data;

    // Request and address hold until acknowledged
    a_req_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_mem_req && !i_mem_ack) |=> (o_mem_req && $stable(o_mem_addr))
    ) else $error("rv_fetch_pc request dropped or address moved before ack");

endmodule

//--- source/rv_fetch_buf.sv
module rv_fetch_buf
    import rv_fetch_pkg::*;
#(
    parameter int INSTR_BUF_ADDR_SIZE = 2    // log2 of depth in parcels
)
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_flush,             // Redirect, drop everything
    input  logic        i_stall,             // Decode not ready
    input  logic        i_fill_valid,        // Non-stale memory word
    input  logic [31:0] i_fill_pc,           // Halfword PC of that read
    input  logic [31:0] i_fill_data,
    output logic        o_free_dword,        // Room for one more word
    output logic        o_instr_valid,
    output logic [31:0] o_instr,             // {second parcel, head parcel}
    output logic [31:0] o_instr_pc
);

    fetch_half_t         push_lo;            // Entry written first
    fetch_half_t         push_hi;            // Upper parcel on double push
    fetch_half_t         head;
    fetch_half_t         next;
    logic [PARCEL_W-1:0] fill_lo;
    logic [PARCEL_W-1:0] fill_hi;
    logic                push_single;
    logic                push_double;
    logic                pop_single;
    logic                pop_double;
    logic                empty;
    logic                has_double;
    logic                free_two;
    logic                head_c;             // Head is a 16-bit instruction
    logic                move;               // Instruction taken by decode

    assign fill_lo = i_fill_data[PARCEL_W-1:0];
    assign fill_hi = i_fill_data[2*PARCEL_W-1:PARCEL_W];

    // Word fetched from an odd halfword only carries its upper parcel
    assign push_double = i_fill_valid && !i_fill_pc[1];
    assign push_single = i_fill_valid && i_fill_pc[1];

    assign push_lo = i_fill_pc[1] ? make_half(i_fill_pc[31:1], fill_hi)
                                  : make_half(i_fill_pc[31:1], fill_lo);
    assign push_hi = make_half({i_fill_pc[31:2], 1'b1}, fill_hi);

    fifo_dual #(
        .T_ENTRY       (fetch_half_t),
        .DEPTH_BITS    (INSTR_BUF_ADDR_SIZE)
    ) u_fifo (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_data0       (push_lo),
        .i_data1       (push_hi),
        .i_push_single (push_single),
        .i_push_double (push_double),
        .i_pop_single  (pop_single),
        .i_pop_double  (pop_double),
        .o_data0       (head),
        .o_data1       (next),
        .o_empty       (empty),
        .o_has_double  (has_double),
        .o_free_two    (free_two)
    );

    assign head_c = is_compressed(head.data);

    // Whole instruction at the head
    assign o_instr_valid = !empty && (head_c || has_double);
    assign move          = o_instr_valid && !i_stall;

    // One parcel for RVC, two for a 32-bit instruction
    assign pop_single = move && head_c;
    assign pop_double = move && !head_c;

    assign o_instr      = {next.data, head.data};   // Upper half ignored for RVC
    assign o_instr_pc   = half_pc(head);
    assign o_free_dword = free_two;

    // Sequencer only requests with two slots free
    a_fill_room: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_fill_valid |-> free_two
    ) else $error("rv_fetch_buf fill without room at PC %h", i_fill_pc);

endmodule

//--- source/fifo_dual.sv
module fifo_dual
    import rv_fetch_pkg::*;
#(
    parameter type T_ENTRY    = fetch_half_t,
    parameter int  DEPTH_BITS = 2
)
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_flush,          // Drop all entries
    input  T_ENTRY i_data0,          // First entry written
    input  T_ENTRY i_data1,          // Second entry, double push only
    input  logic   i_push_single,
    input  logic   i_push_double,
    input  logic   i_pop_single,
    input  logic   i_pop_double,
    output T_ENTRY o_data0,          // Head entry
    output T_ENTRY o_data1,          // Entry after the head
    output logic   o_empty,
    output logic   o_has_double,     // Two or more entries held
    output logic   o_free_two        // Two or more slots free
);

    localparam int DEPTH = 1 << DEPTH_BITS;

    T_ENTRY                mem [DEPTH];     // Circular storage
    logic [DEPTH_BITS-1:0] wr_ptr;
    logic [DEPTH_BITS-1:0] rd_ptr;
    logic [DEPTH_BITS-1:0] wr_ptr_p1;
    logic [DEPTH_BITS-1:0] rd_ptr_p1;
    logic [DEPTH_BITS:0]   count;           // Occupancy, 0..DEPTH
    logic [DEPTH_BITS:0]   free_cnt;
    logic [DEPTH_BITS:0]   push_num;
    logic [DEPTH_BITS:0]   pop_num;

    assign wr_ptr_p1 = wr_ptr + 1'b1;       // Wraps naturally
    assign rd_ptr_p1 = rd_ptr + 1'b1;
    assign free_cnt  = (DEPTH_BITS+1)'(DEPTH) - count;

    // Entries added and removed this cycle
    always_comb begin
        push_num = '0;
        pop_num  = '0;
        if (i_push_double) begin
            push_num = (DEPTH_BITS+1)'(2);
        end else if (i_push_single) begin
            push_num = (DEPTH_BITS+1)'(1);
        end
        if (i_pop_double) begin
            pop_num = (DEPTH_BITS+1)'(2);
        end else if (i_pop_single) begin
            pop_num = (DEPTH_BITS+1)'(1);
        end
    end

    // Storage write, one or two slots
    always_ff @(posedge i_clk) begin
        if (i_push_single || i_push_double) begin
            mem[wr_ptr] <= i_data0;
        end
        if (i_push_double) begin
            mem[wr_ptr_p1] <= i_data1;      // Second slot after wr_ptr
        end
    end

    // Pointers and occupancy
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + push_num[DEPTH_BITS-1:0];
            rd_ptr <= rd_ptr + pop_num[DEPTH_BITS-1:0];
            count  <= count + push_num - pop_num;   // Push and pop may overlap
        end
    end

    assign o_data0      = mem[rd_ptr];
    assign o_data1      = mem[rd_ptr_p1];  // Only meaningful with o_has_double
    assign o_empty      = (count == '0);
    assign o_has_double = (count >= (DEPTH_BITS+1)'(2));
    assign o_free_two   = (free_cnt >= (DEPTH_BITS+1)'(2));

    // Push never exceeds the free space
    a_push_room: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_push_double |-> free_cnt >= (DEPTH_BITS+1)'(2)) and
        (i_push_single |-> free_cnt != '0)
    ) else $error("fifo_dual push with %0d free slots", free_cnt);

    // Pop never takes more than held
    a_pop_count: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_pop_double |-> count >= (DEPTH_BITS+1)'(2)) and
        (i_pop_single |-> count != '0)
    ) else $error("fifo_dual pop with %0d entries", count);

    // Single and double push are exclusive
    a_push_kind: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(i_push_single && i_push_double)
    ) else $error("fifo_dual single and double push together");

endmodule

//--- source/rv_fetch_pkg.sv
package rv_fetch_pkg;

    localparam int PARCEL_W      = 16;            // One RVC parcel
    localparam int PARCEL_ADDR_W = 31;            // Parcel address bits 31..1

    // One buffered parcel with its halfword address
    typedef struct packed {
        logic [PARCEL_ADDR_W-1:0] addr;           // PC[31:1] of this parcel
        logic [PARCEL_W-1:0]      data;           // Raw instruction bits
    } fetch_half_t;

    // Low two bits not 2'b11 means a 16-bit instruction
    function automatic logic is_compressed(input logic [PARCEL_W-1:0] parcel);
        return (parcel[1:0] != 2'b11);
    endfunction

    // Pack address and data into a parcel entry
    function automatic fetch_half_t make_half(
        input logic [PARCEL_ADDR_W-1:0] addr,
        input logic [PARCEL_W-1:0]      data
    );
        fetch_half_t h;
        h.addr = addr;
        h.data = data;
        return h;
    endfunction

    // Full byte PC of a parcel entry
    function automatic logic [31:0] half_pc(input fetch_half_t h);
        return {h.addr, 1'b0};
    endfunction

endpackage
